//--- sys_mapper.f
verilog/bus_pkg.sv
verilog/mapper_pkg.sv
verilog/reg_arbiter.sv
verilog/mapper_regs.sv
verilog/region_decode.sv
verilog/dtack_gen.sv
verilog/irq_ctrl.sv
verilog/sys_mapper.sv
testbench/sys_mapper_checker.sv
testbench/sys_mapper_tb.sv

//--- testbench/sys_mapper_tb.sv
// only region registers and the sound latch are observable; other registers are never read back
`timescale 1ns/1ps
`default_nettype none

module sys_mapper_tb;

    import mapper_pkg::*;

    logic        clk;
    logic        rst;
    logic [23:1] addr;
    logic [15:0] cpu_dout;
    logic [1:0]  dsn;
    logic [1:0]  dswn;
    logic [2:0]  fc;
    logic        asn;
    logic        ext_dackn;
    logic        vint;
    logic        snd_rd;
    logic        mcu_wr;
    logic [4:0]  mcu_addr;
    logic [7:0]  mcu_data;
    logic [3:0]  st_addr;
    logic [7:0]  active;
    logic        dtack_n;
    logic [2:0]  ipl_n;
    logic        vpa_n;
    logic [7:0]  snd_dout;
    logic        snd_obf;
    logic [1:0]  mcu_intn;
    logic [7:0]  st_dout;

    // reference model of the register file
    logic [7:0] img [32];
    logic       own;
    logic       obf;
    int         errors;
    int         checks;
    int         test_err;

    sys_mapper DUT (.*);

    bind sys_mapper sys_mapper_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // inputs change 5 ns after the rising edge
    task automatic next_drive;
        @(posedge clk);
        #5;
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout at %0t: %s never happened", $time, what);
        errors++;
    endtask

    task automatic end_test(input string name);
        $display("%s done, %0d errors", name, errors - test_err);
    endtask

    // expected one-hot region where the lowest index wins since it is applied last
    function automatic logic [7:0] model_active(input logic [23:1] a, input logic [2:0] f);
        logic [7:0] res;
        logic [7:0] base;
        logic [1:0] size;
        int         drop;
        res = 8'h00;
        for (int r = 7; r >= 0; r--) begin
            base = img[17 + 2 * r];
            size = img[16 + 2 * r][1:0];
            // low bits of the top byte stop counting as the region grows
            drop = (size == 2'd0) ? 0 : (size == 2'd1) ? 1 : (size == 2'd2) ? 3 : 5;
            if ((a[23:16] >> drop) == (base >> drop)) begin
                res = 8'h01 << r;
            end
        end
        if (f == 3'b111) begin
            res = 8'h00;
        end
        return res;
    endfunction

    task automatic find_unmapped(output logic [7:0] top);
        logic found;
        found = 1'b0;
        for (int tries = 0; tries < 256 && !found; tries++) begin
            top = 8'($urandom);
            found = model_active({top, 15'h0}, 3'b101) == 8'h00;
        end
        if (!found) begin
            $display("no unmapped address found for a CPU register write");
            errors++;
        end
    endtask

    // one clock with an optional CPU write, MCU write and latch read
    task automatic write_cycle(input logic c_en, input logic [4:0] c_idx, input logic [7:0] c_data,
                               input logic m_en, input logic [4:0] m_idx, input logic [7:0] m_data,
                               input logic rd);
        logic [7:0] top;
        logic       wrote;
        logic [4:0] w_idx;
        find_unmapped(top);
        next_drive;
        if (c_en) begin
            addr     = {top, 10'($urandom), c_idx};
            cpu_dout = {8'($urandom), c_data};
            asn      = 1'b0;
            dsn      = 2'b10;
            dswn     = 2'b10;
            fc       = 3'b101;
        end
        mcu_wr   = m_en;
        mcu_addr = m_idx;
        mcu_data = m_data;
        snd_rd   = rd;
        wrote    = 1'b1;
        w_idx    = 5'd0;
        if (m_en) begin
            img[m_idx] = m_data;
            w_idx      = m_idx;
            own        = 1'b1;
        end else if (c_en && !own) begin
            img[c_idx] = c_data;
            w_idx      = c_idx;
        end else begin
            wrote = 1'b0;
        end
        if (rd) begin
            obf = 1'b0;
        end else if (wrote && w_idx == SND_LATCH_IDX) begin
            obf = 1'b1;
        end
        next_drive;
        asn    = 1'b1;
        dsn    = 2'b11;
        dswn   = 2'b11;
        mcu_wr = 1'b0;
        snd_rd = 1'b0;
    endtask

    // read all 16 region bytes through the status port
    task automatic check_regions;
        for (int sa = 0; sa < 16; sa++) begin
            next_drive;
            st_addr = 4'(sa);
            @(posedge clk);
            #1;
            check("st_dout", img[16 + 2 * (sa % 8) + (sa >= 8 ? 0 : 1)], st_dout);
        end
    endtask

    task automatic check_latch;
        check("snd_obf", obf, snd_obf);
        check("snd_dout", img[SND_LATCH_IDX], snd_dout);
    endtask

    task automatic read_latch;
        next_drive;
        snd_rd = 1'b1;
        obf    = 1'b0;
        next_drive;
        snd_rd = 1'b0;
    endtask

    // read cycle in region 0 that counts edges until dtack_n falls
    task automatic wait_cycle(input logic [1:0] code);
        int edges;
        int delay;
        next_drive;
        addr = {8'h05, 15'($urandom)};
        asn  = 1'b0;
        dsn  = 2'b00;
        dswn = 2'b11;
        fc   = 3'b101;
        #1;
        check("active", model_active(addr, fc), active);
        edges = 0;
        if (code == 2'd3) begin
            delay = $urandom_range(1, 6);
            repeat (delay) begin
                @(posedge clk);
                #1;
                check("dtack_n", 1, dtack_n);
            end
            #4;
            ext_dackn = 1'b0;
        end
        while (dtack_n && edges < 8) begin
            @(posedge clk);
            #1;
            edges++;
        end
        if (dtack_n) begin
            timeout_fail("dtack_n going low");
        end
        check("wait edges", code == 2'd3 ? 1 : code + 1, edges);
        next_drive;
        check("dtack_n", 0, dtack_n);
        asn       = 1'b1;
        dsn       = 2'b11;
        ext_dackn = 1'b1;
        #1;
        check("dtack_n", 1, dtack_n);
    endtask

    task automatic wait_ipl(input logic [2:0] exp);
        int edges;
        edges = 0;
        while (ipl_n !== exp && edges < 4) begin
            @(posedge clk);
            #1;
            edges++;
        end
        if (ipl_n !== exp) begin
            timeout_fail("ipl_n change");
        end
        check("irq edges", 1, edges);
    endtask

    initial begin
        logic [4:0] pick;
        void'($urandom(32'h53b7b007));
        errors = 0;
        checks = 0;
        own    = 1'b0;
        obf    = 1'b0;
        for (int i = 0; i < 32; i++) begin
            img[i] = 8'h00;
        end
        rst       = 1'b1;
        addr      = '0;
        cpu_dout  = '0;
        dsn       = 2'b11;
        dswn      = 2'b11;
        fc        = 3'b101;
        asn       = 1'b1;
        ext_dackn = 1'b1;
        vint      = 1'b0;
        snd_rd    = 1'b0;
        mcu_wr    = 1'b0;
        mcu_addr  = '0;
        mcu_data  = '0;
        st_addr   = '0;
        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;

        test_err = errors;
        check("dtack_n", 1, dtack_n);
        check("ipl_n", 3'b111, ipl_n);
        check("mcu_intn", 2'b11, mcu_intn);
        check("snd_obf", 0, snd_obf);
        repeat (40) write_cycle(1, 5'($urandom), 8'($urandom), 0, 0, 0, 0);
        check_regions;
        check_latch;
        end_test("test 1 cpu register writes");

        // bases below 0x80 keep the upper half of the map free for writes
        // regions 4 to 7 reuse the bases of regions 0 to 3 so that regions overlap
        test_err = errors;
        for (int i = 0; i < 8; i++) begin
            write_cycle(1, REGION_REG_BASE + 5'(2 * i), 8'($urandom), 0, 0, 0, 0);
            write_cycle(1, REGION_REG_BASE + 5'(2 * i + 1),
                        (i < 4) ? {1'b0, 7'($urandom)} : img[17 + 2 * (i - 4)],
                        0, 0, 0, 0);
        end
        check_regions;
        repeat (200) begin
            next_drive;
            addr = 23'($urandom);
            if ($urandom % 2 == 0) begin
                // top byte on a programmed base where two regions overlap
                addr[23:16] = img[17 + 2 * $urandom_range(0, 7)];
            end else if ($urandom % 4 != 0) begin
                addr[23] = 1'b0;
            end
            fc = ($urandom % 5 == 0) ? 3'b111 : 3'($urandom_range(1, 6));
            @(negedge clk);
            check("active", model_active(addr, fc), active);
        end
        fc = 3'b101;
        end_test("test 2 priority decode");

        // region 0 at base 0 with 2048K covers top bytes 00 to 1f
        test_err = errors;
        for (int code = 0; code < 4; code++) begin
            write_cycle(1, REGION_REG_BASE, {4'h0, 2'(code), 2'b11}, 0, 0, 0, 0);
            write_cycle(1, REGION_REG_BASE + 5'd1, 8'h00, 0, 0, 0, 0);
            wait_cycle(2'(code));
        end
        end_test("test 3 wait states");

        test_err = errors;
        read_latch;
        check_latch;
        write_cycle(1, SND_LATCH_IDX, 8'($urandom), 0, 0, 0, 0);
        check_latch;
        read_latch;
        check_latch;
        // read and write in the same clock leave the flag clear
        write_cycle(1, SND_LATCH_IDX, 8'($urandom), 0, 0, 0, 1);
        check_latch;
        end_test("test 5 sound latch");

        test_err = errors;
        next_drive;
        vint = 1'b1;
        wait_ipl(3'b011);
        check("mcu_intn", 2'b10, mcu_intn);
        next_drive;
        fc  = 3'b111;
        asn = 1'b0;
        dsn = 2'b00;
        #1;
        check("vpa_n", 0, vpa_n);
        wait_ipl(3'b111);
        check("mcu_intn", 2'b11, mcu_intn);
        next_drive;
        asn = 1'b1;
        dsn = 2'b11;
        fc  = 3'b101;
        #1;
        check("vpa_n", 1, vpa_n);
        repeat (4) begin
            next_drive;
            check("ipl_n", 3'b111, ipl_n);
        end
        next_drive;
        vint = 1'b0;
        // new edge together with an acknowledge
        next_drive;
        vint = 1'b1;
        fc   = 3'b111;
        asn  = 1'b0;
        dsn  = 2'b00;
        @(posedge clk);
        #1;
        check("ipl_n", 3'b111, ipl_n);
        next_drive;
        asn  = 1'b1;
        dsn  = 2'b11;
        fc   = 3'b101;
        vint = 1'b0;
        @(posedge clk);
        #1;
        check("ipl_n", 3'b111, ipl_n);
        check("mcu_intn", 2'b11, mcu_intn);
        end_test("test 6 interrupt");

        test_err = errors;
        write_cycle(0, 0, 0, 1, REGION_REG_BASE + 5'($urandom_range(0, 15)), 8'($urandom), 0);
        repeat (20) write_cycle(1, REGION_REG_BASE + 5'($urandom_range(0, 15)), 8'($urandom),
                                0, 0, 0, 0);
        repeat (10) write_cycle(0, 0, 0, 1, REGION_REG_BASE + 5'($urandom_range(0, 15)),
                                8'($urandom), 0);
        pick = REGION_REG_BASE + 5'($urandom_range(0, 15));
        write_cycle(1, pick, 8'($urandom), 1, pick, 8'($urandom), 0);
        check_regions;
        end_test("test 4 mcu ownership");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/sys_mapper_checker.sv
// properties are sampled on the rising clk and disabled while rst is high
`timescale 1ns/1ps
`default_nettype none

module sys_mapper_checker (
    input logic       clk,
    input logic       rst,
    input logic       asn,
    input logic       snd_rd,
    input logic [7:0] active,
    input logic       dtack_n,
    input logic [2:0] ipl_n,
    input logic       snd_obf
);

    // at most one region claims a cycle
    a_active_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(active))
        else $error("active has more than one region set: %b", active);

    // no acknowledge outside a bus cycle
    a_dtack_idle: assert property (@(posedge clk) disable iff (rst) asn |-> dtack_n)
        else $error("dtack_n low while asn is high");

    // only level 4 or no request
    a_ipl_level: assert property (@(posedge clk) disable iff (rst)
        ipl_n == 3'b111 || ipl_n == 3'b011)
        else $error("ipl_n shows an unexpected level: %b", ipl_n);

    // the latch flag is cleared only by a read
    a_obf_clear: assert property (@(posedge clk) disable iff (rst)
        $fell(snd_obf) |-> $past(snd_rd))
        else $error("snd_obf fell without snd_rd");

endmodule

`default_nettype wire

//--- verilog/sys_mapper.sv
// mapper top; no bus grant, halt, reset or error outputs, and one state step per clk
`timescale 1ns/1ps
`default_nettype none

module sys_mapper (
    input  logic        clk,
    input  logic        rst,
    input  logic [23:1] addr,
    input  logic [15:0] cpu_dout,
    input  logic [1:0]  dsn,
    input  logic [1:0]  dswn,
    input  logic [2:0]  fc,
    input  logic        asn,
    input  logic        ext_dackn,
    input  logic        vint,
    input  logic        snd_rd,
    input  logic        mcu_wr,
    input  logic [4:0]  mcu_addr,
    input  logic [7:0]  mcu_data,
    input  logic [3:0]  st_addr,
    output logic [7:0]  active,
    output logic        dtack_n,
    output logic [2:0]  ipl_n,
    output logic        vpa_n,
    output logic [7:0]  snd_dout,
    output logic        snd_obf,
    output logic [1:0]  mcu_intn,
    output logic [7:0]  st_dout
);

    import bus_pkg::*;
    import mapper_pkg::*;

    // CPU pins gathered into one cycle
    cpu_bus_t    cpu;
    // granted register write
    reg_wr_t     wr;
    region_map_t map;
    logic [1:0]  wait_code;
    logic        irq_n;

    assign cpu = '{addr: addr, dout: cpu_dout, dsn: dsn, dswn: dswn, fc: fc, asn: asn};

    // MCU only sees the vertical blank line
    assign mcu_intn = {1'b1, irq_n};

    reg_arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .cpu          (cpu),
        .cpu_unmapped (active == 8'h00),
        .mcu_wr       (mcu_wr),
        .mcu_addr     (mcu_addr),
        .mcu_data     (mcu_data),
        .wr           (wr)
    );

    mapper_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .wr       (wr),
        .snd_rd   (snd_rd),
        .st_addr  (st_addr),
        .map      (map),
        .snd_dout (snd_dout),
        .snd_obf  (snd_obf),
        .st_dout  (st_dout)
    );

    region_decode u_decode (
        .cpu       (cpu),
        .map       (map),
        .active    (active),
        .wait_code (wait_code)
    );

    dtack_gen u_dtack (
        .clk       (clk),
        .rst       (rst),
        .cpu       (cpu),
        .wait_code (wait_code),
        .ext_dackn (ext_dackn),
        .dtack_n   (dtack_n)
    );

    irq_ctrl u_irq (
        .clk   (clk),
        .rst   (rst),
        .cpu   (cpu),
        .vint  (vint),
        .ipl_n (ipl_n),
        .vpa_n (vpa_n),
        .irq_n (irq_n)
    );

endmodule

`default_nettype wire

//--- verilog/irq_ctrl.sv
// level 4 only; vint is assumed synchronous to clk, and acknowledge beats a new edge
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::cpu_bus_t cpu,
    input  logic              vint,
    output logic [2:0]        ipl_n,
    output logic              vpa_n,
    output logic              irq_n
);

    import bus_pkg::*;

    // vint one clock late, for edge detect
    logic vint_d;
    // interrupt acknowledge cycle in progress
    logic inta;

    assign inta = (cpu.fc == FC_INT_ACK) & ~cpu.asn;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vint_d <= 1'b0;
            irq_n  <= 1'b1;
        end else begin
            vint_d <= vint;
            if (inta) begin
                irq_n <= 1'b1;
            end else if (vint && !vint_d) begin
                irq_n <= 1'b0;
            end
        end
    end

    // autovector during the acknowledge
    assign vpa_n = ~inta;
    // pending request shows as level 4 (011)
    assign ipl_n = {irq_n, 2'b11};

endmodule

`default_nettype wire

//--- verilog/dtack_gen.sv
// one wait step per clk; wait code 3 waits on ext_dackn with no timeout, dtack_n rises with asn
`timescale 1ns/1ps
`default_nettype none

module dtack_gen (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::cpu_bus_t cpu,
    input  logic [1:0]        wait_code,
    input  logic              ext_dackn,
    output logic              dtack_n
);

    import mapper_pkg::*;

    // address strobe with at least one data strobe
    logic       bus_active;
    // edges seen in this cycle, saturates at 3
    logic [1:0] cnt;
    // acknowledge reached, held until asn rises
    logic       ack;

    assign bus_active = ~cpu.asn & ~(&cpu.dsn);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= 2'd0;
            ack <= 1'b0;
        end else if (cpu.asn) begin
            cnt <= 2'd0;
            ack <= 1'b0;
        end else if (bus_active) begin
            if (cnt != 2'd3) begin
                cnt <= cnt + 2'd1;
            end
            if (!ack) begin
                // cnt holds the edges before this one
                // so code n fires on edge n+1
                if (wait_code == WAIT_EXT) begin
                    ack <= ~ext_dackn;
                end else begin
                    ack <= cnt == wait_code;
                end
            end
        end
    end

    // end of cycle releases the acknowledge at once
    assign dtack_n = cpu.asn | ~ack;

endmodule

`default_nettype wire

//--- verilog/region_decode.sv
// purely combinational; lowest region wins and nothing matches during an interrupt acknowledge
`timescale 1ns/1ps
`default_nettype none

module region_decode (
    input  bus_pkg::cpu_bus_t       cpu,
    input  mapper_pkg::region_map_t map,
    output logic [7:0]              active,
    output logic [1:0]              wait_code
);

    import bus_pkg::*;
    import mapper_pkg::*;

    // raw match per region before priority
    logic [7:0] hit;
    // set once a lower region has claimed the address
    logic       found;

    // compare top address bits with the base byte
    // fewer bits count as the region grows
    always_comb begin
        for (int r = 0; r < 8; r++) begin
            case (map.ctrl[r].fields.size_code)
                SIZE_64K:   hit[r] = cpu.addr[23:16] == map.base[r];
                SIZE_128K:  hit[r] = cpu.addr[23:17] == map.base[r][7:1];
                SIZE_512K:  hit[r] = cpu.addr[23:19] == map.base[r][7:3];
                SIZE_2048K: hit[r] = cpu.addr[23:21] == map.base[r][7:5];
                default:    hit[r] = 1'b0;
            endcase
        end
    end

    // priority pick, region 0 first
    always_comb begin
        active    = 8'h00;
        wait_code = 2'd0;
        found     = 1'b0;
        for (int r = 0; r < 8; r++) begin
            if (!found && hit[r]) begin
                active[r] = 1'b1;
                wait_code = map.ctrl[r].fields.wait_code;
                found     = 1'b1;
            end
        end
        // acknowledge cycle carries the level, not an address
        if (cpu.fc == FC_INT_ACK) begin
            active    = 8'h00;
            wait_code = 2'd0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mapper_regs.sv
// 32 byte registers cleared by reset; st_dout lags st_addr by one clock, snd_rd beats a latch write
`timescale 1ns/1ps
`default_nettype none

module mapper_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  bus_pkg::reg_wr_t        wr,
    input  logic                    snd_rd,
    input  logic [3:0]              st_addr,
    output mapper_pkg::region_map_t map,
    output logic [7:0]              snd_dout,
    output logic                    snd_obf,
    output logic [7:0]              st_dout
);

    import mapper_pkg::*;

    logic [7:0] regs [32];
    // bit 3 of st_addr picks control (1) or base (0)
    logic [4:0] st_idx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (wr.en) begin
            regs[wr.idx] <= wr.data;
        end
    end

    // latch full flag
    // read clears it and takes priority over a new write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_obf <= 1'b0;
        end else if (snd_rd) begin
            snd_obf <= 1'b0;
        end else if (wr.en && wr.idx == SND_LATCH_IDX) begin
            snd_obf <= 1'b1;
        end
    end

    assign snd_dout = regs[SND_LATCH_IDX];

    // region registers as seen by the decoder
    always_comb begin
        for (int r = 0; r < 8; r++) begin
            map.ctrl[r].raw = regs[REGION_REG_BASE + 5'(2 * r)];
            map.base[r]     = regs[REGION_REG_BASE + 5'(2 * r) + 5'd1];
        end
    end

    // flip of st_addr[3] since base sits on the odd index
    assign st_idx = REGION_REG_BASE + {1'b0, st_addr[2:0], ~st_addr[3]};

    // status port one clock behind st_addr
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st_dout <= 8'h00;
        end else begin
            st_dout <= regs[st_idx];
        end
    end

endmodule

`default_nettype wire

//--- verilog/reg_arbiter.sv
// CPU writes go only to unmapped space on the lower byte; the MCU keeps the registers until reset
`timescale 1ns/1ps
`default_nettype none

module reg_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  bus_pkg::cpu_bus_t   cpu,
    input  logic                cpu_unmapped,
    input  logic                mcu_wr,
    input  logic [4:0]          mcu_addr,
    input  logic [7:0]          mcu_data,
    output bus_pkg::reg_wr_t    wr
);

    // set by the first MCU write, sticky
    logic mcu_own;
    // CPU request before arbitration
    logic cpu_req;

    // lower byte write while no region claims the address
    assign cpu_req = ~cpu.asn & ~cpu.dswn[0] & cpu_unmapped;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mcu_own <= 1'b0;
        end else if (mcu_wr) begin
            mcu_own <= 1'b1;
        end
    end

    // MCU always wins
    // CPU passes only while it still owns the file and the MCU is idle
    always_comb begin
        if (mcu_wr) begin
            wr.en   = 1'b1;
            wr.idx  = mcu_addr;
            wr.data = mcu_data;
        end else begin
            wr.en   = cpu_req & ~mcu_own;
            // word address bits 5:1 pick the register
            wr.idx  = cpu.addr[5:1];
            wr.data = cpu.dout[7:0];
        end
    end

endmodule

`default_nettype wire

//--- verilog/mapper_pkg.sv
// region register layout of the mapper; eight regions and a 32-byte map are fixed by the device
`default_nettype none

package mapper_pkg;

    // register file layout
    // index 3 is the sound latch shared with the sound CPU
    localparam logic [4:0] SND_LATCH_IDX = 5'd3;
    // region r uses two bytes starting at 16
    //   16 + 2r     control byte
    //   16 + 2r + 1 base byte (address bits 23:16)
    localparam logic [4:0] REGION_REG_BASE = 5'd16;

    // size codes, compared bits counted from address bit 23
    localparam logic [1:0] SIZE_64K   = 2'd0;
    localparam logic [1:0] SIZE_128K  = 2'd1;
    localparam logic [1:0] SIZE_512K  = 2'd2;
    localparam logic [1:0] SIZE_2048K = 2'd3;

    // wait code 3 hands the acknowledge to the external pin
    localparam logic [1:0] WAIT_EXT = 2'd3;

    // control byte, written and read back as raw, decoded as fields
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] reserved;
            // 0..2 give 1..3 clocks, 3 uses ext_dackn
            logic [1:0] wait_code;
            logic [1:0] size_code;
        } fields;
    } region_ctrl_u;

    // all eight regions as seen by the decoder
    typedef struct packed {
        logic [7:0][7:0]   base;
        region_ctrl_u [7:0] ctrl;
    } region_map_t;

endpackage

`default_nettype wire

//--- verilog/bus_pkg.sv
// 68000 bus and register write types; addr is a word address, all strobes are active low
`default_nettype none

package bus_pkg;

    // function code seen on an interrupt acknowledge cycle
    localparam logic [2:0] FC_INT_ACK = 3'b111;

    // one CPU bus cycle as sampled at the pins
    typedef struct packed {
        // word address, bit 0 is implied by the data strobes
        logic [23:1] addr;
        // write data from the CPU
        logic [15:0] dout;
        // data strobes, bit 1 upper byte, bit 0 lower byte
        logic [1:0]  dsn;
        // write strobes per byte lane
        logic [1:0]  dswn;
        // function code
        logic [2:0]  fc;
        // address strobe
        logic        asn;
    } cpu_bus_t;

    // single byte write into the mapper register file
    typedef struct packed {
        logic       en;
        // register index 0 to 31
        logic [4:0] idx;
        logic [7:0] data;
    } reg_wr_t;

endpackage

`default_nettype wire
